/* Bender.yml */
package:
  name: alu_core

sources:
  - files:
      - logic/alu_pkg.sv
      - logic/operand_select.sv
      - logic/alu_lane.sv
      - logic/result_flags.sv
      - logic/alu_core.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/alu_tb.sv

/* all.f */
logic/alu_pkg.sv
logic/operand_select.sv
logic/alu_lane.sv
logic/result_flags.sv
logic/alu_core.sv
test/tb_clock.sv
test/alu_tb.sv

/* logic/alu_core.sv */
`timescale 1ns/10ps

module alu_core (
    input  logic              clk,
    input  logic              rst,
    input  alu_pkg::alu_req_t req,
    output alu_pkg::alu_rsp_t rsp
);
    import alu_pkg::*;

    lane_in_t  [NUM_LANES-1:0] lane_in;
    lane_out_t [NUM_LANES-1:0] lane_out;
    lane_fn_e                  lane_fn;
    logic      [NUM_LANES-1:0] lane_cin;  // ripple carry into each lane
    logic                      a_sign;
    logic                      b_sign;
    flags_t                    flags;

    operand_select i_operand_select (
        .req      (req),
        .flags    (flags),
        .lane_in  (lane_in),
        .lane_fn  (lane_fn),
        .carry_in (lane_cin[0]),
        .a_sign   (a_sign),
        .b_sign   (b_sign)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        if (i > 0) begin : g_chain
            assign lane_cin[i] = lane_out[i-1].carry_out;
        end
        alu_lane i_alu_lane (
            .lane_in  (lane_in[i]),
            .lane_fn  (lane_fn),
            .carry_in (lane_cin[i]),
            .lane_out (lane_out[i])
        );
    end

    result_flags i_result_flags (
        .clk      (clk),
        .rst      (rst),
        .valid    (req.valid),
        .op       (req.op),
        .width    (req.width),
        .a_sign   (a_sign),
        .b_sign   (b_sign),
        .lane_out (lane_out),
        .flags    (flags),
        .rsp      (rsp)
    );

endmodule

/* logic/alu_lane.sv */
`timescale 1ns/10ps

module alu_lane (
    input  alu_pkg::lane_in_t  lane_in,
    input  alu_pkg::lane_fn_e  lane_fn,
    input  logic               carry_in,
    output alu_pkg::lane_out_t lane_out
);
    import alu_pkg::*;

    logic [4:0] lo_sum;  // low nibble with carry in bit 4
    logic [4:0] hi_sum;
    logic [4:0] lo_dif;  // bit 4 is the borrow
    logic [4:0] hi_dif;

    assign lo_sum = {1'b0, lane_in.a[3:0]} + {1'b0, lane_in.b[3:0]} + {4'd0, carry_in};
    assign hi_sum = {1'b0, lane_in.a[7:4]} + {1'b0, lane_in.b[7:4]} + {4'd0, lo_sum[4]};

    assign lo_dif = {1'b0, lane_in.a[3:0]} - {1'b0, lane_in.b[3:0]} - {4'd0, carry_in};
    assign hi_dif = {1'b0, lane_in.a[7:4]} - {1'b0, lane_in.b[7:4]} - {4'd0, lo_dif[4]};

    always_comb begin
        lane_out.carry_out = 1'b0;  // logic functions never carry
        lane_out.half      = 1'b0;
        unique case (lane_fn)
            LF_ADD: begin
                lane_out.result    = {hi_sum[3:0], lo_sum[3:0]};
                lane_out.carry_out = hi_sum[4];
                lane_out.half      = lo_sum[4];
            end
            LF_SUB: begin
                lane_out.result    = {hi_dif[3:0], lo_dif[3:0]};
                lane_out.carry_out = hi_dif[4];
                lane_out.half      = lo_dif[4];
            end
            LF_AND: begin
                lane_out.result = lane_in.a & lane_in.b;
            end
            LF_OR: begin
                lane_out.result = lane_in.a | lane_in.b;
            end
            LF_XOR: begin
                lane_out.result = lane_in.a ^ lane_in.b;
            end
            default: begin
                lane_out.result = lane_in.b;  // pass-through for move
            end
        endcase
    end

endmodule

/* logic/alu_pkg.sv */
package alu_pkg;

    localparam int NUM_LANES = 4;  // byte lanes across the 32-bit datapath
    localparam int LANE_BITS = 8;

    typedef enum logic [3:0] {
        OP_MOVE = 4'd0,
        OP_ADD  = 4'd1,
        OP_ADC  = 4'd2,  // add with carry flag
        OP_SUB  = 4'd3,
        OP_SBC  = 4'd4,  // subtract with carry flag as borrow
        OP_CP   = 4'd5,  // subtract for flags only
        OP_AND  = 4'd6,
        OP_OR   = 4'd7,
        OP_XOR  = 4'd8
    } alu_op_e;

    typedef enum logic [1:0] {
        W_BYTE = 2'd0,
        W_WORD = 2'd1,
        W_LONG = 2'd2
    } width_e;

    typedef struct packed {
        logic        valid;
        alu_op_e     op;
        width_e      width;
        logic        use_imm;  // take imm instead of op1 as source
        logic [31:0] op0;      // destination operand
        logic [31:0] op1;      // source operand
        logic [31:0] imm;
    } alu_req_t;

    typedef enum logic [2:0] {
        LF_ADD  = 3'd0,
        LF_SUB  = 3'd1,
        LF_AND  = 3'd2,
        LF_OR   = 3'd3,
        LF_XOR  = 3'd4,
        LF_PASS = 3'd5   // forwards b
    } lane_fn_e;

    typedef struct packed {
        logic [LANE_BITS-1:0] a;
        logic [LANE_BITS-1:0] b;
    } lane_in_t;

    typedef struct packed {
        logic [LANE_BITS-1:0] result;
        logic                 carry_out;  // borrow when subtracting
        logic                 half;       // out of the low nibble
    } lane_out_t;

    // same bit order as the CPU flag byte
    typedef struct packed {
        logic s;
        logic z;
        logic pad5;
        logic h;
        logic pad3;
        logic v;
        logic n;
        logic c;
    } flags_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] dout;
        flags_t      flags;
    } alu_rsp_t;

endpackage

/* logic/operand_select.sv */
`timescale 1ns/10ps

module operand_select (
    input  alu_pkg::alu_req_t                        req,
    input  alu_pkg::flags_t                          flags,
    output alu_pkg::lane_in_t [alu_pkg::NUM_LANES-1:0] lane_in,
    output alu_pkg::lane_fn_e                        lane_fn,
    output logic                                     carry_in,
    output logic                                     a_sign,
    output logic                                     b_sign
);
    import alu_pkg::*;

    logic [31:0] src;

    assign src = req.use_imm ? req.imm : req.op1;

    // both operands cut into bytes, lane 0 holds the low byte
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_in[i].a = req.op0[i*LANE_BITS +: LANE_BITS];
            lane_in[i].b = src[i*LANE_BITS +: LANE_BITS];
        end
    end

    always_comb begin
        unique case (req.op)
            OP_ADD, OP_ADC:        lane_fn = LF_ADD;
            OP_SUB, OP_SBC, OP_CP: lane_fn = LF_SUB;  // compare is a subtract
            OP_AND:                lane_fn = LF_AND;
            OP_OR:                 lane_fn = LF_OR;
            OP_XOR:                lane_fn = LF_XOR;
            default:               lane_fn = LF_PASS; // move forwards src
        endcase
    end

    // C flag feeds lane 0 only for the carry forms
    assign carry_in = (req.op == OP_ADC || req.op == OP_SBC) ? flags.c : 1'b0;

    always_comb begin
        unique case (req.width)
            W_BYTE: begin
                a_sign = req.op0[7];
                b_sign = src[7];
            end
            W_WORD: begin
                a_sign = req.op0[15];
                b_sign = src[15];
            end
            default: begin
                a_sign = req.op0[31];
                b_sign = src[31];
            end
        endcase
    end

endmodule

/* logic/result_flags.sv */
`timescale 1ns/10ps

module result_flags (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      valid,
    input  alu_pkg::alu_op_e                          op,
    input  alu_pkg::width_e                           width,
    input  logic                                      a_sign,
    input  logic                                      b_sign,
    input  alu_pkg::lane_out_t [alu_pkg::NUM_LANES-1:0] lane_out,
    output alu_pkg::flags_t                           flags,
    output alu_pkg::alu_rsp_t                         rsp
);
    import alu_pkg::*;

    logic [31:0] result;
    logic        res_sign;
    logic        res_zero;
    logic        res_carry;
    logic        res_even;   // even parity for logic ops
    logic        add_ovf;
    logic        sub_ovf;
    flags_t      flag_nx;
    flags_t      flag_q;
    logic [31:0] dout_q;
    logic        valid_q;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            result[i*LANE_BITS +: LANE_BITS] = lane_out[i].result;
        end
    end

    always_comb begin
        unique case (width)
            W_BYTE: begin
                res_sign  = result[7];
                res_zero  = (result[7:0] == 8'd0);
                res_carry = lane_out[0].carry_out;
            end
            W_WORD: begin
                res_sign  = result[15];
                res_zero  = (result[15:0] == 16'd0);
                res_carry = lane_out[1].carry_out;
            end
            default: begin
                res_sign  = result[31];
                res_zero  = (result == 32'd0);
                res_carry = lane_out[3].carry_out;
            end
        endcase
    end

    assign res_even = (width == W_BYTE) ? ~^result[7:0] : ~^result[15:0];

    // signed overflow from operand and result signs
    assign add_ovf = (a_sign == b_sign) && (res_sign != a_sign);
    assign sub_ovf = (a_sign != b_sign) && (res_sign != a_sign);

    always_comb begin
        flag_nx = flag_q;  // move and unknown codes keep flags
        unique case (op)
            OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP: begin
                flag_nx.s = res_sign;
                flag_nx.z = res_zero;
                flag_nx.h = lane_out[0].half;
                flag_nx.v = (op == OP_ADD || op == OP_ADC) ? add_ovf : sub_ovf;
                flag_nx.n = !(op == OP_ADD || op == OP_ADC);
                flag_nx.c = res_carry;
            end
            OP_AND, OP_OR, OP_XOR: begin
                flag_nx.s = res_sign;
                flag_nx.z = res_zero;
                flag_nx.h = (op == OP_AND);
                flag_nx.v = res_even;
                flag_nx.n = 1'b0;
                flag_nx.c = 1'b0;
            end
            default: ;
        endcase
        flag_nx.pad5 = 1'b0;
        flag_nx.pad3 = 1'b0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            dout_q  <= '0;
            flag_q  <= '0;
        end else begin
            valid_q <= valid;
            if (valid && op != OP_CP) begin
                dout_q <= result;  // compare leaves dout alone
            end
            if (valid) begin
                flag_q <= flag_nx;
            end
        end
    end

    assign flags = flag_q;  // back to operand_select for ADC/SBC
    assign rsp   = '{valid: valid_q, dout: dout_q, flags: flag_q};

endmodule

/* test/alu_tb.sv */
`timescale 1ns/10ps

module alu_tb;
    import alu_pkg::*;

    localparam int NUM_RANDOM     = 600;
    localparam int TIMEOUT_CYCLES = 1500;  // about twice the stimulus length

    logic        clk;
    logic        rst;
    alu_req_t    req;
    alu_rsp_t    rsp;
    alu_rsp_t    exp_rsp;   // reference model state
    logic [31:0] rng;
    logic        armed;
    int          cycles;

    tb_clock i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    alu_core i_alu_core (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // corner values mixed into the random operands
    function automatic logic [31:0] corner_value(input logic [3:0] idx);
        case (idx % 10)
            0: return 32'h0000_0000;
            1: return 32'h0000_00ff;
            2: return 32'h0000_007f;
            3: return 32'h0000_0080;
            4: return 32'h0000_ffff;
            5: return 32'h0000_7fff;
            6: return 32'h0000_8000;
            7: return 32'hffff_ffff;
            8: return 32'h7fff_ffff;
            default: return 32'h8000_0000;
        endcase
    endfunction

    function automatic logic [31:0] pick_operand();
        logic [31:0] sel;
        sel = next_rand();
        if (sel[3:0] < 4'd4) begin
            return corner_value(sel[7:4]);
        end
        return next_rand();
    endfunction

    // next response from the flag and result rules
    function automatic alu_rsp_t expected_response(input alu_req_t r, input alu_rsp_t prev);
        alu_rsp_t    nx;
        logic [31:0] src;
        logic [31:0] res;
        logic [63:0] mask;
        logic [63:0] wide;
        logic [4:0]  nib;
        logic        cin;
        logic        sa;
        logic        sb;
        logic        sr;
        int          w;
        nx       = prev;
        nx.valid = 1'b1;
        src      = r.use_imm ? r.imm : r.op1;
        cin      = (r.op == OP_ADC || r.op == OP_SBC) ? prev.flags.c : 1'b0;
        w        = (r.width == W_BYTE) ? 8 : (r.width == W_WORD) ? 16 : 32;
        mask     = (64'd1 << w) - 64'd1;
        sa       = r.op0[w-1];
        sb       = src[w-1];
        case (r.op)
            OP_ADD, OP_ADC: begin
                res        = r.op0 + src + cin;
                wide       = ({32'd0, r.op0} & mask) + ({32'd0, src} & mask) + cin;
                nib        = {1'b0, r.op0[3:0]} + {1'b0, src[3:0]} + cin;
                sr         = res[w-1];
                nx.dout    = res;
                nx.flags.c = wide[w];
                nx.flags.h = nib[4];
                nx.flags.v = (sa == sb) && (sr != sa);
                nx.flags.n = 1'b0;
            end
            OP_SUB, OP_SBC, OP_CP: begin
                res  = r.op0 - src - cin;
                wide = ({32'd0, r.op0} & mask) - ({32'd0, src} & mask) - cin;
                nib  = {1'b0, r.op0[3:0]} - {1'b0, src[3:0]} - cin;
                sr   = res[w-1];
                if (r.op != OP_CP) begin
                    nx.dout = res;  // compare keeps dout
                end
                nx.flags.c = wide[w];
                nx.flags.h = nib[4];
                nx.flags.v = (sa != sb) && (sr != sa);
                nx.flags.n = 1'b1;
            end
            OP_AND, OP_OR, OP_XOR: begin
                res = (r.op == OP_AND) ? (r.op0 & src) :
                      (r.op == OP_OR)  ? (r.op0 | src) : (r.op0 ^ src);
                nx.dout    = res;
                nx.flags.c = 1'b0;
                nx.flags.h = (r.op == OP_AND);
                nx.flags.v = (r.width == W_BYTE) ? ~^res[7:0] : ~^res[15:0];
                nx.flags.n = 1'b0;
            end
            default: begin
                nx.dout = src;  // move, flags untouched
                return nx;
            end
        endcase
        nx.flags.s = res[w-1];
        nx.flags.z = (({32'd0, res} & mask) == 64'd0);
        return nx;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_rsp <= '0;
        end else if (req.valid) begin
            exp_rsp <= expected_response(req, exp_rsp);
        end else begin
            exp_rsp.valid <= 1'b0;
        end
    end

    always @(posedge clk) begin
        armed  <= 1'b1;
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    // all checks sampled mid-cycle where rsp and the model are settled
    check_reset: assert property (@(negedge clk) disable iff (!armed) rst |-> rsp == '0)
        else begin
            $display("MISMATCH rsp expected %h actual %h", 41'h0, rsp);
            $display("TEST FAILED");
            $fatal(1, "reset state");
        end

    check_valid: assert property (@(negedge clk) disable iff (!armed)
                                  rsp.valid == exp_rsp.valid)
        else begin
            $display("MISMATCH rsp.valid expected %h actual %h", exp_rsp.valid, rsp.valid);
            $display("TEST FAILED");
            $fatal(1, "response timing");
        end

    check_dout: assert property (@(negedge clk) disable iff (!armed)
                                 rsp.dout == exp_rsp.dout)
        else begin
            $display("MISMATCH rsp.dout expected %h actual %h", exp_rsp.dout, rsp.dout);
            $display("TEST FAILED");
            $fatal(1, "result value");
        end

    check_flags: assert property (@(negedge clk) disable iff (!armed)
                                  rsp.flags == exp_rsp.flags)
        else begin
            $display("MISMATCH rsp.flags expected %h actual %h", exp_rsp.flags, rsp.flags);
            $display("TEST FAILED");
            $fatal(1, "flag value");
        end

    task automatic drive_request(input alu_op_e op, input width_e width, input logic use_imm,
                                 input logic [31:0] op0, input logic [31:0] op1,
                                 input logic [31:0] imm);
        @(posedge clk);
        #1;
        req.valid   = 1'b1;
        req.op      = op;
        req.width   = width;
        req.use_imm = use_imm;
        req.op0     = op0;
        req.op1     = op1;
        req.imm     = imm;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        req.valid = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        req    = '0;
        rng    = 32'hbad;
        armed  = 1'b0;
        cycles = 0;

        @(negedge rst);
        repeat (3) idle_cycle();  // outputs stay at reset values

        drive_request(OP_ADD, W_BYTE, 1'b0, 32'h0000_00ff, 32'h1, 32'h0);
        drive_request(OP_ADD, W_WORD, 1'b1, 32'h0000_7fff, 32'h0, 32'h1);
        drive_request(OP_ADD, W_LONG, 1'b0, 32'hffff_ffff, 32'h1, 32'h0);
        drive_request(OP_ADC, W_LONG, 1'b0, 32'h0, 32'h0, 32'h0);  // carry from last cycle
        drive_request(OP_ADD, W_BYTE, 1'b0, 32'h80, 32'h80, 32'h0);
        drive_request(OP_ADC, W_WORD, 1'b0, 32'h1234, 32'h4321, 32'h0);
        drive_request(OP_SUB, W_BYTE, 1'b0, 32'h10, 32'h20, 32'h0);
        drive_request(OP_SBC, W_BYTE, 1'b0, 32'h10, 32'h0f, 32'h0);
        idle_cycle();
        drive_request(OP_SBC, W_WORD, 1'b1, 32'h8000, 32'h0, 32'h1);
        drive_request(OP_CP, W_LONG, 1'b0, 32'h5, 32'h5, 32'h0);
        drive_request(OP_MOVE, W_BYTE, 1'b1, 32'hdead, 32'h1111, 32'hcafe_f00d);
        drive_request(OP_MOVE, W_LONG, 1'b0, 32'h0, 32'h8000_0000, 32'h0);
        drive_request(OP_AND, W_BYTE, 1'b0, 32'h0000_f0f3, 32'h0000_0f37, 32'h0);
        drive_request(OP_OR, W_WORD, 1'b1, 32'h0001_0100, 32'h0, 32'h0000_00ff);
        drive_request(OP_XOR, W_LONG, 1'b0, 32'hffff_0000, 32'hffff_ffff, 32'h0);
        repeat (2) idle_cycle();

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = next_rand();
            drive_request(alu_op_e'(4'(r % 9)), width_e'(2'((r >> 8) % 3)), r[4],
                          pick_operand(), pick_operand(), pick_operand());
            if (r[20] && r[21]) begin
                idle_cycle();
            end
        end
        repeat (3) idle_cycle();

        $display("TEST OK");
        $finish;
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;  // released just after the fourth edge
    end

endmodule
